// ==== hw/soc_mmio_pkg.sv ====
package soc_mmio_pkg;

  // address map
  localparam int unsigned MEM_WORDS  = 32768;
  localparam int unsigned RAM_ADDR_W = $clog2(MEM_WORDS);
  localparam logic [23:0] MMIO_PAGE  = 24'h030000;
  localparam int unsigned GPIO_W     = 16;

  // gpio register set
  localparam logic [7:0] OFS_GPIO_DATA = 8'h00;
  localparam logic [7:0] OFS_GPIO_OEB  = 8'h04;
  localparam logic [7:0] OFS_GPIO_PU   = 8'h08;
  localparam logic [7:0] OFS_GPIO_PD   = 8'h0c;

  // housekeeping spi status, read only
  localparam logic [7:0] OFS_HK_CONFIG = 8'h18;
  localparam logic [7:0] OFS_HK_ENA    = 8'h1c;
  localparam logic [7:0] OFS_HK_PLL    = 8'h20;
  localparam logic [7:0] OFS_HK_MFGR   = 8'h24;
  localparam logic [7:0] OFS_HK_PROD   = 8'h28;
  localparam logic [7:0] OFS_HK_MASK   = 8'h2c;
  localparam logic [7:0] OFS_CLK_SEL   = 8'h30;

  // routing
  localparam logic [7:0] OFS_PLL_DEST  = 8'h38;
  localparam logic [7:0] OFS_TRAP_DEST = 8'h3c;
  localparam logic [7:0] OFS_IRQ7_SRC  = 8'h40;
  localparam logic [7:0] OFS_IRQ8_SRC  = 8'h44;

  // pin groups claimed by the routed signals
  localparam int unsigned PLL_PIN_LO  = 8;
  localparam int unsigned TRAP_PIN_LO = 11;
  localparam int unsigned ROUTE_GRP_W = 3;
  localparam int unsigned IRQ7_PIN_LO = 0;
  localparam int unsigned IRQ8_PIN_LO = 3;

  localparam logic [GPIO_W-1:0] GPIO_OEB_RST = '1;
  localparam logic [GPIO_W-1:0] GPIO_RST     = '0;

  // upper bits all zero means inside the ram window
  typedef struct packed {
    logic [31-RAM_ADDR_W-2:0] upper;
    logic [RAM_ADDR_W-1:0]    word;
    logic [1:0]               byte_ofs;
  } addr_ram_t;

  typedef struct packed {
    logic [23:0] page;
    logic [7:0]  ofs;
  } addr_mmio_t;

  typedef union packed {
    addr_ram_t  ram;
    addr_mmio_t mmio;
  } bus_addr_u;

  typedef struct packed {
    logic        valid;
    bus_addr_u   addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } bus_req_t;

  typedef enum logic [1:0] {
    OP_RAM,
    OP_REG,
    OP_NONE
  } op_kind_e;

  typedef struct packed {
    op_kind_e    kind;
    logic [7:0]  ofs;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        write;
  } dec_op_t;

  typedef struct packed {
    logic [3:0]            wstrb;
    logic [RAM_ADDR_W-1:0] addr;
    logic [31:0]           wdata;
  } ram_req_t;

  typedef struct packed {
    logic [GPIO_W-1:0] out;
    logic [GPIO_W-1:0] outenb;
    logic [GPIO_W-1:0] pullupb;
    logic [GPIO_W-1:0] pulldownb;
  } pad_ctrl_t;

  typedef struct packed {
    logic [1:0] pll_dest;
    logic [1:0] trap_dest;
    logic [1:0] irq7_src;
    logic [1:0] irq8_src;
  } route_cfg_t;

  localparam route_cfg_t ROUTE_RST = '0;

  typedef struct packed {
    logic [7:0]  cfg;
    logic        xtal_ena;
    logic        reg_ena;
    logic [3:0]  pll_trim;
    logic        pll_cp_ena;
    logic        pll_vco_ena;
    logic        pll_bias_ena;
    logic [11:0] mfgr_id;
    logic [7:0]  prod_id;
    logic [3:0]  mask_rev;
    logic        clk_ext_sel;
  } hk_status_t;

endpackage

// ==== hw/mmio_decode.sv ====
`timescale 1ns/100ps

module mmio_decode (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  soc_mmio_pkg::bus_req_t req_i,
  input  logic                   resp_done_i,
  output soc_mmio_pkg::ram_req_t ram_o,
  output soc_mmio_pkg::dec_op_t  op_o,
  output logic                   op_valid_o
);
  import soc_mmio_pkg::*;

  logic     busy_q;
  logic     accept;
  op_kind_e kind;

  // one request in flight, held until ready comes back
  assign accept = req_i.valid && !busy_q;

  always_comb begin
    if (req_i.addr.ram.upper == '0) begin
      kind = OP_RAM;
    end else if (req_i.addr.mmio.page == MMIO_PAGE) begin
      kind = OP_REG;
    end else begin
      kind = OP_NONE;
    end
  end

  // ram sees the access in the accepting cycle, data comes back a cycle later
  assign ram_o.wstrb = (accept && kind == OP_RAM) ? req_i.wstrb : 4'h0;
  assign ram_o.addr  = req_i.addr.ram.word;
  assign ram_o.wdata = req_i.wdata;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q     <= 1'b0;
      op_valid_o <= 1'b0;
    end else begin
      op_valid_o <= accept;
      if (accept) begin
        busy_q <= 1'b1;
      end else if (resp_done_i) begin
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_o.kind  <= kind;
      op_o.ofs   <= req_i.addr.mmio.ofs;
      op_o.wdata <= req_i.wdata;
      op_o.wstrb <= req_i.wstrb;
      op_o.write <= |req_i.wstrb;
    end
  end

endmodule

// ==== hw/mmio_regs.sv ====
`timescale 1ns/100ps

module mmio_regs (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  soc_mmio_pkg::dec_op_t             op_i,
  input  logic                              op_valid_i,
  input  logic [31:0]                       ram_rdata_i,
  input  logic [soc_mmio_pkg::GPIO_W-1:0]   gpio_in_i,
  input  logic [soc_mmio_pkg::GPIO_W-1:0]   pin_out_i,
  input  soc_mmio_pkg::hk_status_t          status_i,
  output soc_mmio_pkg::pad_ctrl_t           gpio_o,
  output soc_mmio_pkg::route_cfg_t          route_o,
  output logic                              ready_o,
  output logic [31:0]                       rdata_o
);
  import soc_mmio_pkg::*;

  logic        reg_wr;
  logic [31:0] rd_val;

  // byte lanes follow the write strobe
  function automatic logic [GPIO_W-1:0] lane_merge(
    input logic [GPIO_W-1:0] cur,
    input logic [31:0]       wdata,
    input logic [3:0]        wstrb
  );
    logic [GPIO_W-1:0] nxt;
    nxt = cur;
    for (int b = 0; b < GPIO_W / 8; b++) begin
      if (wstrb[b]) begin
        nxt[b*8 +: 8] = wdata[b*8 +: 8];
      end
    end
    return nxt;
  endfunction

  assign reg_wr = op_valid_i && op_i.kind == OP_REG && op_i.write;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gpio_o.out       <= GPIO_RST;
      gpio_o.outenb    <= GPIO_OEB_RST;
      gpio_o.pullupb   <= GPIO_RST;
      gpio_o.pulldownb <= GPIO_RST;
      route_o          <= ROUTE_RST;
    end else if (reg_wr) begin
      case (op_i.ofs)
        OFS_GPIO_DATA: begin
          gpio_o.out <= lane_merge(gpio_o.out, op_i.wdata, op_i.wstrb);
        end
        OFS_GPIO_OEB: begin
          gpio_o.outenb <= lane_merge(gpio_o.outenb, op_i.wdata, op_i.wstrb);
        end
        OFS_GPIO_PU: begin
          gpio_o.pullupb <= lane_merge(gpio_o.pullupb, op_i.wdata, op_i.wstrb);
        end
        OFS_GPIO_PD: begin
          gpio_o.pulldownb <= lane_merge(gpio_o.pulldownb, op_i.wdata, op_i.wstrb);
        end
        OFS_PLL_DEST: begin
          if (op_i.wstrb[0]) route_o.pll_dest <= op_i.wdata[1:0];
        end
        OFS_TRAP_DEST: begin
          if (op_i.wstrb[0]) route_o.trap_dest <= op_i.wdata[1:0];
        end
        OFS_IRQ7_SRC: begin
          if (op_i.wstrb[0]) route_o.irq7_src <= op_i.wdata[1:0];
        end
        OFS_IRQ8_SRC: begin
          if (op_i.wstrb[0]) route_o.irq8_src <= op_i.wdata[1:0];
        end
        default: begin
        end
      endcase
    end
  end

  // read data reflects the state before this access writes it
  always_comb begin
    rd_val = '0;
    case (op_i.kind)
      OP_RAM: rd_val = ram_rdata_i;
      OP_REG: begin
        case (op_i.ofs)
          // routed outputs above raw pin inputs
          OFS_GPIO_DATA: rd_val = {pin_out_i, gpio_in_i};
          OFS_GPIO_OEB:  rd_val = 32'(gpio_o.outenb);
          OFS_GPIO_PU:   rd_val = 32'(gpio_o.pullupb);
          OFS_GPIO_PD:   rd_val = 32'(gpio_o.pulldownb);
          OFS_HK_CONFIG: rd_val = 32'(status_i.cfg);
          OFS_HK_ENA:    rd_val = 32'({status_i.xtal_ena, status_i.reg_ena});
          OFS_HK_PLL: begin
            rd_val = 32'({status_i.pll_trim, status_i.pll_cp_ena,
                          status_i.pll_vco_ena, status_i.pll_bias_ena});
          end
          OFS_HK_MFGR:   rd_val = 32'(status_i.mfgr_id);
          OFS_HK_PROD:   rd_val = 32'(status_i.prod_id);
          OFS_HK_MASK:   rd_val = 32'(status_i.mask_rev);
          OFS_CLK_SEL:   rd_val = 32'(status_i.clk_ext_sel);
          OFS_PLL_DEST:  rd_val = 32'(route_o.pll_dest);
          OFS_TRAP_DEST: rd_val = 32'(route_o.trap_dest);
          OFS_IRQ7_SRC:  rd_val = 32'(route_o.irq7_src);
          OFS_IRQ8_SRC:  rd_val = 32'(route_o.irq8_src);
          default:       rd_val = '0;
        endcase
      end
      default: rd_val = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ready_o <= 1'b0;
    end else begin
      ready_o <= op_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (op_valid_i) begin
      rdata_o <= rd_val;
    end
  end

endmodule

// ==== hw/pad_route.sv ====
`timescale 1ns/100ps

module pad_route (
  input  logic                            rst_n_i,
  input  soc_mmio_pkg::pad_ctrl_t         gpio_i,
  input  soc_mmio_pkg::route_cfg_t        route_i,
  input  logic                            trap_i,
  input  logic                            pll_clk_i,
  input  logic [soc_mmio_pkg::GPIO_W-1:0] gpio_in_i,
  output soc_mmio_pkg::pad_ctrl_t         pads_o,
  output logic                            irq7_o,
  output logic                            irq8_o
);
  import soc_mmio_pkg::*;

  // a routed group drives out, pulls off
  function automatic pad_ctrl_t claim_group(
    input pad_ctrl_t   pads,
    input int unsigned lo
  );
    pad_ctrl_t p;
    p = pads;
    p.outenb[lo +: ROUTE_GRP_W]    = '0;
    p.pullupb[lo +: ROUTE_GRP_W]   = '1;
    p.pulldownb[lo +: ROUTE_GRP_W] = '1;
    return p;
  endfunction

  function automatic logic irq_pick(
    input logic [GPIO_W-1:0] pins,
    input logic [1:0]        src,
    input int unsigned       lo
  );
    if (src == 2'd0) begin
      return 1'b0;
    end
    return pins[lo + src - 1];
  endfunction

  always_comb begin
    pads_o = gpio_i;
    // only two pll pins, dest 3 still claims the group
    if (route_i.pll_dest == 2'd1 || route_i.pll_dest == 2'd2) begin
      pads_o.out[PLL_PIN_LO + route_i.pll_dest - 1] = pll_clk_i;
    end
    if (route_i.pll_dest != 2'd0) begin
      pads_o = claim_group(pads_o, PLL_PIN_LO);
    end
    if (route_i.trap_dest != 2'd0) begin
      pads_o.out[TRAP_PIN_LO + route_i.trap_dest - 1] = trap_i;
      pads_o = claim_group(pads_o, TRAP_PIN_LO);
    end
    // pads stay tristate while in reset
    if (!rst_n_i) begin
      pads_o.outenb = '1;
    end
  end

  assign irq7_o = irq_pick(gpio_in_i, route_i.irq7_src, IRQ7_PIN_LO);
  assign irq8_o = irq_pick(gpio_in_i, route_i.irq8_src, IRQ8_PIN_LO);

endmodule

// ==== hw/soc_mmio.sv ====
`timescale 1ns/100ps

module soc_mmio (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  soc_mmio_pkg::bus_req_t          req_i,
  output logic                            mem_ready_o,
  output logic [31:0]                     mem_rdata_o,
  output soc_mmio_pkg::ram_req_t          ram_o,
  input  logic [31:0]                     ram_rdata_i,
  input  logic [soc_mmio_pkg::GPIO_W-1:0] gpio_in_i,
  input  logic                            trap_i,
  input  logic                            pll_clk_i,
  input  soc_mmio_pkg::hk_status_t        status_i,
  output soc_mmio_pkg::pad_ctrl_t         pads_o,
  output logic                            irq7_o,
  output logic                            irq8_o
);
  import soc_mmio_pkg::*;

  dec_op_t    op;
  logic       op_valid;
  pad_ctrl_t  gpio_regs;
  route_cfg_t route;

  mmio_decode u_decode (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_i      (req_i),
    .resp_done_i(mem_ready_o),
    .ram_o      (ram_o),
    .op_o       (op),
    .op_valid_o (op_valid)
  );

  mmio_regs u_regs (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .op_i       (op),
    .op_valid_i (op_valid),
    .ram_rdata_i(ram_rdata_i),
    .gpio_in_i  (gpio_in_i),
    .pin_out_i  (pads_o.out),
    .status_i   (status_i),
    .gpio_o     (gpio_regs),
    .route_o    (route),
    .ready_o    (mem_ready_o),
    .rdata_o    (mem_rdata_o)
  );

  // data register reads back the pins as routed
  pad_route u_pad (
    .rst_n_i  (rst_n_i),
    .gpio_i   (gpio_regs),
    .route_i  (route),
    .trap_i   (trap_i),
    .pll_clk_i(pll_clk_i),
    .gpio_in_i(gpio_in_i),
    .pads_o   (pads_o),
    .irq7_o   (irq7_o),
    .irq8_o   (irq8_o)
  );

endmodule

// ==== bench/soc_mmio_checker.sv ====
`timescale 1ns/100ps

module soc_mmio_checker (
  input logic                   clk_i,
  input logic                   rst_n_i,
  input soc_mmio_pkg::bus_req_t req_i,
  input logic                   ready_i,
  input soc_mmio_pkg::ram_req_t ram_i
);
  import soc_mmio_pkg::*;

  int   fail_cnt = 0;
  logic busy_q;
  logic accept;
  logic ram_hit;

  // one request in flight, freed by the ready pulse
  assign accept  = req_i.valid && !busy_q;
  assign ram_hit = req_i.addr < 4 * MEM_WORDS;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
    end else if (accept) begin
      busy_q <= 1'b1;
    end else if (ready_i) begin
      busy_q <= 1'b0;
    end
  end

  ready_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ready_i |=> !ready_i)
    else begin
      $error("ready stayed high for two cycles");
      fail_cnt++;
    end

  ready_after_accept: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    accept |=> !ready_i ##1 ready_i)
    else begin
      $error("ready did not follow the accept by two cycles");
      fail_cnt++;
    end

  ram_strobe_gated: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(accept && ram_hit) |-> ram_i.wstrb == 4'h0)
    else begin
      $error("ram strobe active without a ram access");
      fail_cnt++;
    end

endmodule

// ==== bench/soc_mmio_tb.sv ====
`timescale 1ns/100ps

module soc_mmio_tb;
  import soc_mmio_pkg::*;

  localparam int unsigned CLK_PERIOD = 20;
  localparam int unsigned DRIVE_DLY  = 2;
  localparam int unsigned RST_CYCLES = 4;
  localparam logic [15:0] LFSR_SEED  = 16'd28204;
  localparam logic [15:0] LFSR_TAPS  = 16'hb400;
  // pads right after reset and with the gpio registers set up
  localparam logic [63:0] PADS_RST   = 64'h0000_ffff_0000_0000;
  localparam logic [63:0] PADS_BASE  = 64'h2400_0f0f_00f0_3c00;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  strb;
    logic        write;
    logic        rnd;
    logic [15:0] gpio_in;
    logic        trap;
    logic        pll;
    logic [31:0] exp_rdata;
    logic [63:0] exp_pads;
    logic        exp_irq7;
    logic        exp_irq8;
  } row_t;

  logic        clk;
  logic        rst_n;
  bus_req_t    req;
  logic        mem_ready;
  logic [31:0] mem_rdata;
  ram_req_t    ram;
  logic [31:0] ram_rdata;
  logic [15:0] gpio_in;
  logic        trap;
  logic        pll_clk;
  hk_status_t  status;
  pad_ctrl_t   pads;
  logic        irq7;
  logic        irq8;

  logic [31:0] ram_mem [MEM_WORDS];
  row_t        rows[$];
  logic [15:0] lfsr_q;
  logic [31:0] last_rnd;
  int unsigned cycle_cnt = 0;
  int unsigned cycle_limit = 0;

  soc_mmio dut_i (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .req_i      (req),
    .mem_ready_o(mem_ready),
    .mem_rdata_o(mem_rdata),
    .ram_o      (ram),
    .ram_rdata_i(ram_rdata),
    .gpio_in_i  (gpio_in),
    .trap_i     (trap),
    .pll_clk_i  (pll_clk),
    .status_i   (status),
    .pads_o     (pads),
    .irq7_o     (irq7),
    .irq8_o     (irq8)
  );

  bind soc_mmio soc_mmio_checker chk_i (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .req_i  (req_i),
    .ready_i(mem_ready_o),
    .ram_i  (ram_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // synchronous ram, old contents on a same-word read
  always @(posedge clk) begin
    for (int b = 0; b < 4; b++) begin
      if (ram.wstrb[b]) begin
        ram_mem[ram.addr][b*8 +: 8] <= ram.wdata[b*8 +: 8];
      end
    end
    ram_rdata <= ram_mem[ram.addr];
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit != 0 && cycle_cnt > cycle_limit) begin
      stop_run("timeout: the tests did not finish within the cycle limit");
    end
  end

  always @(negedge clk) begin
    if (dut_i.chk_i.fail_cnt != 0) begin
      stop_run("a bus timing assertion in the checker failed");
    end
  end

  function automatic logic [31:0] fill_word(int unsigned idx);
    return {~16'(idx), 16'(idx)};
  endfunction

  function automatic logic [15:0] lfsr_step(logic [15:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  task automatic next_rand32(output logic [31:0] v);
    for (int i = 0; i < 32; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v[i] = lfsr_q[0];
    end
  endtask

  task automatic stop_run(string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_val(string name, logic [63:0] got, logic [63:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("ERR %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic add_row(logic [31:0] addr, logic [31:0] wdata, logic [3:0] strb,
                         logic write, logic rnd, logic [15:0] gin, logic trap_v,
                         logic pll_v, logic [31:0] exp_rd, logic [63:0] exp_pads,
                         logic exp_irq7, logic exp_irq8);
    rows.push_back(row_t'({addr, wdata, strb, write, rnd, gin, trap_v, pll_v,
                           exp_rd, exp_pads, exp_irq7, exp_irq8}));
  endtask

  task automatic build_table();
    // addr, wdata, strb, write, rnd, gpio_in, trap, pll, rdata, pads, irq7, irq8
    add_row('h03000000, 'h0, 'h0, 0, 0, 'h0000, 0, 0, 'h0, PADS_RST, 0, 0);
    add_row('h03000038, 'h0, 'h0, 0, 0, 'h0000, 0, 0, 'h0, PADS_RST, 0, 0);
    add_row('h0300003c, 'h0, 'h0, 0, 0, 'h0000, 0, 0, 'h0, PADS_RST, 0, 0);
    add_row('h03000040, 'h0, 'h0, 0, 0, 'h0000, 0, 0, 'h0, PADS_RST, 0, 0);
    add_row('h03000044, 'h0, 'h0, 0, 0, 'h0000, 0, 0, 'h0, PADS_RST, 0, 0);
    // byte lanes of the gpio registers
    add_row('h03000000, 'h1234a55a, 'h1, 1, 0, 'h0, 0, 0, 'h0, 64'h005a_ffff_0000_0000, 0, 0);
    add_row('h03000000, 'h0000c300, 'h2, 1, 0, 'h0, 0, 0, 'h0, 64'hc35a_ffff_0000_0000, 0, 0);
    add_row('h03000004, 'hffff0f0f, 'hf, 1, 0, 'h0, 0, 0, 'h0, 64'hc35a_0f0f_0000_0000, 0, 0);
    add_row('h03000008, 'h000000f0, 'h1, 1, 0, 'h0, 0, 0, 'h0, 64'hc35a_0f0f_00f0_0000, 0, 0);
    add_row('h0300000c, 'h00003c00, 'h2, 1, 0, 'h0, 0, 0, 'h0, 64'hc35a_0f0f_00f0_3c00, 0, 0);
    add_row('h03000000, 'h0, 'h0, 0, 0, 'hbeef, 0, 0, 'hc35abeef, 64'hc35a_0f0f_00f0_3c00, 0, 0);
    add_row('h03000004, 'h0, 'h0, 0, 0, 'h0, 0, 0, 'h00000f0f, 64'hc35a_0f0f_00f0_3c00, 0, 0);
    add_row('h03000008, 'h0, 'h0, 0, 0, 'h0, 0, 0, 'h000000f0, 64'hc35a_0f0f_00f0_3c00, 0, 0);
    add_row('h0300000c, 'h0, 'h0, 0, 0, 'h0, 0, 0, 'h00003c00, 64'hc35a_0f0f_00f0_3c00, 0, 0);
    add_row('h03000000, 'h00002400, 'hf, 1, 0, 'h0, 0, 0, 'h0, PADS_BASE, 0, 0);
    // pll clock onto pins 8 and 9
    add_row('h03000038, 'h1, 'h1, 1, 0, 'h0, 0, 1, 'h0, 64'h2500_080f_07f0_3f00, 0, 0);
    add_row('h03000000, 'h0, 'h0, 0, 0, 'h0, 0, 0, 'h24000000, 64'h2400_080f_07f0_3f00, 0, 0);
    add_row('h03000038, 'h2, 'h1, 1, 0, 'h0, 0, 1, 'h0, 64'h2600_080f_07f0_3f00, 0, 0);
    add_row('h03000038, 'h3, 'h1, 1, 0, 'h0, 0, 1, 'h0, 64'h2400_080f_07f0_3f00, 0, 0);
    add_row('h03000038, 'h0, 'h1, 1, 0, 'h0, 0, 1, 'h0, PADS_BASE, 0, 0);
    // trap onto pins 11 to 13
    add_row('h0300003c, 'h1, 'h1, 1, 0, 'h0, 1, 0, 'h0, 64'h2c00_070f_38f0_3c00, 0, 0);
    add_row('h0300003c, 'h2, 'h1, 1, 0, 'h0, 1, 0, 'h0, 64'h3400_070f_38f0_3c00, 0, 0);
    add_row('h0300003c, 'h3, 'h1, 1, 0, 'h0, 0, 0, 'h0, 64'h0400_070f_38f0_3c00, 0, 0);
    add_row('h0300003c, 'h0, 'h0, 0, 0, 'h0, 1, 0, 'h3, 64'h2400_070f_38f0_3c00, 0, 0);
    add_row('h0300003c, 'h0, 'h1, 1, 0, 'h0, 1, 0, 'h0, PADS_BASE, 0, 0);
    // interrupt sources
    add_row('h03000040, 'h1, 'h1, 1, 0, 'h0001, 0, 0, 'h0, PADS_BASE, 1, 0);
    add_row('h03000040, 'h2, 'h1, 1, 0, 'h0001, 0, 0, 'h0, PADS_BASE, 0, 0);
    add_row('h03000040, 'h3, 'h1, 1, 0, 'h0004, 0, 0, 'h0, PADS_BASE, 1, 0);
    add_row('h03000044, 'h1, 'h1, 1, 0, 'h0008, 0, 0, 'h0, PADS_BASE, 0, 1);
    add_row('h03000044, 'h2, 'h1, 1, 0, 'h0010, 0, 0, 'h0, PADS_BASE, 0, 1);
    add_row('h03000044, 'h3, 'h1, 1, 0, 'h001c, 0, 0, 'h0, PADS_BASE, 1, 0);
    add_row('h03000044, 'h0, 'h0, 0, 0, 'h0020, 0, 0, 'h3, PADS_BASE, 0, 1);
    add_row('h03000040, 'h0, 'h1, 1, 0, 'h003f, 0, 0, 'h0, PADS_BASE, 0, 1);
    add_row('h03000044, 'h0, 'h1, 1, 0, 'h003f, 0, 0, 'h0, PADS_BASE, 0, 0);
    // status words
    add_row('h03000018, 'h0, 'h0, 0, 0, 'h0, 0, 0, 'h000000a7, PADS_BASE, 0, 0);
    add_row('h0300001c, 'h0, 'h0, 0, 0, 'h0, 0, 0, 'h00000002, PADS_BASE, 0, 0);
    add_row('h03000020, 'h0, 'h0, 0, 0, 'h0, 0, 0, 'h00000065, PADS_BASE, 0, 0);
    add_row('h03000024, 'h0, 'h0, 0, 0, 'h0, 0, 0, 'h00000456, PADS_BASE, 0, 0);
    add_row('h03000028, 'h0, 'h0, 0, 0, 'h0, 0, 0, 'h00000011, PADS_BASE, 0, 0);
    add_row('h0300002c, 'h0, 'h0, 0, 0, 'h0, 0, 0, 'h00000003, PADS_BASE, 0, 0);
    add_row('h03000030, 'h0, 'h0, 0, 0, 'h0, 0, 0, 'h00000001, PADS_BASE, 0, 0);
    // unmapped offsets and addresses outside both windows
    add_row('h03000014, 'hffffffff, 'hf, 1, 0, 'h0, 0, 0, 'h0, PADS_BASE, 0, 0);
    add_row('h03000014, 'h0, 'h0, 0, 0, 'h0, 0, 0, 'h0, PADS_BASE, 0, 0);
    add_row('h04000000, 'hffffffff, 'hf, 1, 0, 'h0, 0, 0, 'h0, PADS_BASE, 0, 0);
    add_row('h03010004, 'hffffffff, 'hf, 1, 0, 'h0, 0, 0, 'h0, PADS_BASE, 0, 0);
    add_row('h00020000, 'h0, 'h0, 0, 0, 'h0, 0, 0, 'h0, PADS_BASE, 0, 0);
    add_row('h03000000, 'h0, 'h0, 0, 0, 'h0, 0, 0, 'h24000000, PADS_BASE, 0, 0);
    // ram window
    add_row('h00000100, 'hdeadbeef, 'h3, 1, 0, 'h0, 0, 0, 'h0, PADS_BASE, 0, 0);
    add_row('h00000100, 'h0, 'h0, 0, 0, 'h0, 0, 0, 'hffbfbeef, PADS_BASE, 0, 0);
    add_row('h0000048c, 'h0, 'h0, 0, 0, 'h0, 0, 0, 'hfedc0123, PADS_BASE, 0, 0);
    add_row('h0001fffc, 'h0, 'hf, 1, 1, 'h0, 0, 0, 'h0, PADS_BASE, 0, 0);
    add_row('h0001fffc, 'h0, 'h0, 0, 1, 'h0, 0, 0, 'h0, PADS_BASE, 0, 0);
  endtask

  task automatic apply_row(row_t r);
    logic [31:0] wd;
    logic [31:0] exp_rd;
    int unsigned waited;
    wd = r.wdata;
    exp_rd = r.exp_rdata;
    if (r.rnd && r.write) begin
      next_rand32(wd);
      last_rnd = wd;
    end else if (r.rnd) begin
      exp_rd = last_rnd;
    end
    @(posedge clk);
    #DRIVE_DLY;
    req.valid = 1'b1;
    req.addr  = r.addr;
    req.wdata = wd;
    req.wstrb = r.write ? r.strb : 4'h0;
    gpio_in   = r.gpio_in;
    trap      = r.trap;
    pll_clk   = r.pll;
    // ram request is visible before the accepting edge
    @(negedge clk);
    if (r.addr < 4 * MEM_WORDS) begin
      check_val("ram_o.wstrb", ram.wstrb, req.wstrb);
      check_val("ram_o.addr", ram.addr, r.addr[16:2]);
      if (r.write) begin
        check_val("ram_o.wdata", ram.wdata, wd);
      end
    end else begin
      check_val("ram_o.wstrb", ram.wstrb, 4'h0);
    end
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
      @(negedge clk);
    end while (!mem_ready && waited < 8);
    if (!mem_ready) begin
      stop_run("no ready from the DUT within eight cycles of valid");
    end
    if (waited != 2) begin
      stop_run($sformatf("ready came %0d cycles after valid instead of 2", waited));
    end
    if (!r.write) begin
      check_val("mem_rdata_o", mem_rdata, exp_rd);
    end
    check_val("pads_o", pads, r.exp_pads);
    check_val("irq7_o", irq7, r.exp_irq7);
    check_val("irq8_o", irq8, r.exp_irq8);
    @(posedge clk);
    #DRIVE_DLY;
    req = '0;
  endtask

  initial begin
    rst_n     = 1'b0;
    req       = '0;
    gpio_in   = '0;
    trap      = 1'b0;
    pll_clk   = 1'b0;
    ram_rdata = '0;
    status    = {8'ha7, 1'b1, 1'b0, 4'hc, 1'b1, 1'b0, 1'b1, 12'h456, 8'h11, 4'h3, 1'b1};
    lfsr_q    = LFSR_SEED;
    last_rnd  = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      ram_mem[i] = fill_word(i);
    end
    build_table();
    cycle_limit = 4 * rows.size() * 5;
    repeat (RST_CYCLES) @(posedge clk);
    // pads tristate while reset is held
    check_val("pads_o.outenb", pads.outenb, 16'hffff);
    #DRIVE_DLY;
    rst_n = 1'b1;
    @(negedge clk);
    check_val("mem_ready_o", mem_ready, 1'b0);
    check_val("ram_o.wstrb", ram.wstrb, 4'h0);
    foreach (rows[i]) begin
      apply_row(rows[i]);
    end
    if (dut_i.chk_i.fail_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      stop_run($sformatf("%0d bus timing assertions failed", dut_i.chk_i.fail_cnt));
    end
    $finish;
  end

endmodule

// ==== soc_mmio.f ====
hw/soc_mmio_pkg.sv
hw/mmio_decode.sv
hw/mmio_regs.sv
hw/pad_route.sv
hw/soc_mmio.sv
bench/soc_mmio_checker.sv
bench/soc_mmio_tb.sv

// ==== Bender.yml ====
package:
  name: soc_mmio

sources:
  - files:
      - hw/soc_mmio_pkg.sv
      - hw/mmio_decode.sv
      - hw/mmio_regs.sv
      - hw/pad_route.sv
      - hw/soc_mmio.sv
  - target: test
    files:
      - bench/soc_mmio_checker.sv
      - bench/soc_mmio_tb.sv
